// ==== build.f ====
source/cdcPkg.sv
source/bitSynchronizer.sv
source/resetSynchronizer.sv
source/dualClockFifo.sv
source/dualClockFifoWithDataValid.sv
source/creditIssuer.sv
source/outputScheduler.sv
source/cdcStreamBridge.sv
sim/tbCdcStreamBridge.sv

// ==== sim/tbCdcStreamBridge.sv ====
`timescale 1ns/1ps

module tbCdcStreamBridge import cdcPkg::*; ();

    localparam int WORD_COUNT     = 400;
    localparam int RESET_CYCLES   = 16;
    localparam int FIFO_SLOTS     = 2**DEPTH_LOG2_DEFAULT - 1;
    localparam int PAUSE_AFTER    = 150;  // words delivered before the consumer stalls
    localparam int PAUSE_CYCLES   = 300;  // coreClk cycles without returned credits
    // 400 words at a few clk cycles each plus the 450 clk cycle stall, with wide margin
    localparam int TIMEOUT_CYCLES = 20000;

    logic                          clk         = 1'b0;
    logic                          coreClk     = 1'b0;
    logic                          aresetnIn   = 1'b0;
    logic                          inValid     = 1'b0;
    logic [DATA_WIDTH_DEFAULT-1:0] inData      = '0;
    logic                          outCreditIn = 1'b0;
    logic                          creditOut;
    logic                          outValid;
    logic [DATA_WIDTH_DEFAULT-1:0] outData;

    logic [31:0] producerRng = 32'd15;
    logic [31:0] consumerRng = 32'd15;
    logic        aresetnPrev = 1'b0;  // aresetnIn one clk edge ago
    logic        pausing     = 1'b0;
    logic        pauseDone   = 1'b0;
    logic        sawFull     = 1'b0;  // FIFO reached 15 pending words during the stall

    int cycleCount      = 0;
    int creditsHeld     = 0;  // producer credits not yet spent
    int creditsReceived = 0;
    int wordsSent       = 0;
    int wordsDelivered  = 0;
    int creditsReturned = 0;
    int creditsOwed     = 0;  // consumer credits waiting to go back
    int pauseAge        = 0;
    int valueErrors     = 0;
    int otherErrors     = 0;

    logic [DATA_WIDTH_DEFAULT-1:0] expectedWords[$];

    always #2 clk = ~clk;
    always #3 coreClk = ~coreClk;

    cdcStreamBridge dut (
        .clk        (clk),
        .coreClk    (coreClk),
        .aresetnIn  (aresetnIn),
        .inValid    (inValid),
        .inData     (inData),
        .creditOut  (creditOut),
        .outCreditIn(outCreditIn),
        .outValid   (outValid),
        .outData    (outData)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] state);
        logic [31:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic reportValueError(input string msg);
        valueErrors++;
        $display("CHECK FAILED at %t: %s", $realtime, msg);
    endtask

    task automatic reportFailure(input string msg);
        otherErrors++;
        $display("%s", msg);
    endtask

    // producer: spends each received credit on a random later cycle
    always @(posedge clk) begin
        int          avail;
        logic [31:0] rnd;
        logic [31:0] word;
        rnd = xorshift32(producerRng);
        word = rnd ^ 32'(wordsSent);  // running count mixed with noise
        producerRng <= rnd;
        cycleCount <= cycleCount + 1;
        aresetnPrev <= aresetnIn;
        avail = creditsHeld;
        if (creditOut === 1'b1) begin
            avail = avail + 1;
            creditsReceived <= creditsReceived + 1;
        end
        if (avail > 0 && wordsSent < WORD_COUNT && rnd[1:0] != 2'b00) begin
            inValid <= 1'b1;
            inData <= word;
            expectedWords.push_back(word);
            wordsSent <= wordsSent + 1;
            avail = avail - 1;
        end else begin
            inValid <= 1'b0;
        end
        creditsHeld <= avail;
        if (pausing && creditsReceived - wordsDelivered == FIFO_SLOTS) begin
            sawFull <= 1'b1;
        end
    end

    // consumer and scoreboard
    always @(posedge coreClk) begin
        int          owed;
        logic [31:0] rnd;
        logic [31:0] expected;
        rnd = xorshift32(consumerRng);
        consumerRng <= rnd;
        owed = creditsOwed;
        if (outCreditIn) begin
            creditsReturned <= creditsReturned + 1;
        end
        if (outValid === 1'b1) begin
            owed = owed + 1;
            wordsDelivered <= wordsDelivered + 1;
            assert (expectedWords.size() > 0)
                else reportFailure("a word came out although none was waiting to be delivered");
            if (expectedWords.size() > 0) begin
                expected = expectedWords.pop_front();
                assert (outData === expected)
                    else reportValueError($sformatf("word %0d is %h, expected %h",
                                                    wordsDelivered, outData, expected));
            end
        end
        if (pausing) begin
            pauseAge <= pauseAge + 1;
            if (pauseAge == PAUSE_CYCLES - 1) begin
                pausing <= 1'b0;
                pauseDone <= 1'b1;
            end
        end else if (!pauseDone && wordsDelivered >= PAUSE_AFTER) begin
            pausing <= 1'b1;  // one long stall of returned credits
        end
        if (!pausing && owed > 0 && rnd[4]) begin
            outCreditIn <= 1'b1;
            owed = owed - 1;
        end else begin
            outCreditIn <= 1'b0;
        end
        creditsOwed <= owed;
    end

    // outputs quiet in reset and on the first edge after release, once X has cleared
    assert property (@(posedge clk)
        (cycleCount >= 8 && !(aresetnIn && aresetnPrev)) |->
            (creditOut === 1'b0 && outValid === 1'b0))
        else reportValueError("creditOut or outValid high during reset");

    assert property (@(posedge clk) creditsReceived >= wordsSent)
        else reportValueError("producer sent a word without a credit");

    assert property (@(posedge clk) creditsReceived - wordsDelivered <= FIFO_SLOTS)
        else reportValueError("more credits granted than FIFO slots");

    assert property (@(posedge clk)
        (creditsReceived - wordsDelivered == FIFO_SLOTS) |-> (creditOut !== 1'b1))
        else reportValueError("credit granted with the FIFO full");

    assert property (@(posedge coreClk)
        (outValid === 1'b1) |-> (wordsDelivered + 1 <= OUT_CREDITS_DEFAULT + creditsReturned))
        else reportValueError("outValid without a downstream credit");

    // by the end of the stall every held credit is spent, and none beyond
    assert property (@(posedge coreClk)
        (pausing && pauseAge == PAUSE_CYCLES - 1) |->
            (wordsDelivered == OUT_CREDITS_DEFAULT + creditsReturned))
        else reportValueError("held downstream credits not spent by the end of the stall");

    initial begin
        $timeformat(-9, 1, " ns", 10);
        repeat (RESET_CYCLES) @(posedge clk);
        aresetnIn <= 1'b1;
        while (wordsDelivered < WORD_COUNT && cycleCount < TIMEOUT_CYCLES) begin
            @(posedge clk);
        end
        if (wordsDelivered < WORD_COUNT) begin
            reportFailure($sformatf("timeout: %0d of %0d words delivered after %0d clk cycles",
                                    wordsDelivered, WORD_COUNT, cycleCount));
        end else begin
            repeat (50) @(posedge clk);  // any stray extra word shows up here
            if (expectedWords.size() != 0) begin
                reportFailure($sformatf("%0d sent words were never delivered",
                                        expectedWords.size()));
            end
            if (wordsDelivered != WORD_COUNT) begin
                reportFailure($sformatf("%0d words delivered instead of %0d",
                                        wordsDelivered, WORD_COUNT));
            end
            if (!sawFull) begin
                reportFailure("the FIFO never filled up during the consumer stall");
            end
        end
        $display("check errors: %0d, other errors: %0d", valueErrors, otherErrors);
        if (valueErrors == 0 && otherErrors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== source/bitSynchronizer.sv ====
`timescale 1ns/1ps

// carries Gray-coded or slowly changing values only, one bit moves per update
module bitSynchronizer import cdcPkg::*; #(
    parameter int WIDTH       = 1,
    parameter int SYNC_STAGES = SYNC_STAGES_DEFAULT
) (
    input  logic             clk,
    input  logic             aresetnIn,
    input  logic [WIDTH-1:0] dataIn,
    output logic [WIDTH-1:0] dataOut
);

    logic [SYNC_STAGES-1:0][WIDTH-1:0] syncChain; // stage 0 samples the foreign domain

    always_ff @(posedge clk or negedge aresetnIn) begin
        if (!aresetnIn) begin
            syncChain <= '0;
        end else begin
            syncChain <= {syncChain[SYNC_STAGES-2:0], dataIn};
        end
    end

    assign dataOut = syncChain[SYNC_STAGES-1];

endmodule

// ==== source/cdcPkg.sv ====
package cdcPkg;

    // stream word width
    localparam int DATA_WIDTH_DEFAULT = 32;

    // 16 slots, one kept free so full and empty differ
    localparam int DEPTH_LOG2_DEFAULT = 4;

    // flops per synchronizer chain
    localparam int SYNC_STAGES_DEFAULT = 3;

    // credits the consumer holds for the bridge after reset
    localparam int OUT_CREDITS_DEFAULT = 4;

    // width of the upstream and downstream credit counters
    localparam int CREDIT_WIDTH = 8;

endpackage

// ==== source/cdcStreamBridge.sv ====
`timescale 1ns/1ps

module cdcStreamBridge import cdcPkg::*; #(
    parameter int DATA_WIDTH  = DATA_WIDTH_DEFAULT,
    parameter int DEPTH_LOG2  = DEPTH_LOG2_DEFAULT,
    parameter int SYNC_STAGES = SYNC_STAGES_DEFAULT,
    parameter int OUT_CREDITS = OUT_CREDITS_DEFAULT
) (
    input  logic                  clk,          // producer domain
    input  logic                  coreClk,      // consumer domain
    input  logic                  aresetnIn,

    input  logic                  inValid,
    input  logic [DATA_WIDTH-1:0] inData,
    output logic                  creditOut,

    input  logic                  outCreditIn,
    output logic                  outValid,
    output logic [DATA_WIDTH-1:0] outData
);

    logic                  producerResetn;
    logic                  consumerResetn;
    logic [DEPTH_LOG2-1:0] wrUsedCount;
    logic                  readEnable;
    logic                  rdEmpty;

    resetSynchronizer #(
        .SYNC_STAGES(SYNC_STAGES)
    ) producerResetSync (
        .clk      (clk),
        .aresetnIn(aresetnIn),
        .resetnOut(producerResetn)
    );

    resetSynchronizer #(
        .SYNC_STAGES(SYNC_STAGES)
    ) consumerResetSync (
        .clk      (coreClk),
        .aresetnIn(aresetnIn),
        .resetnOut(consumerResetn)
    );

    creditIssuer #(
        .DEPTH_LOG2  (DEPTH_LOG2),
        .CREDIT_WIDTH(CREDIT_WIDTH)
    ) issuer (
        .clk        (clk),
        .resetn     (producerResetn),
        .inValid    (inValid),
        .wrUsedCount(wrUsedCount),
        .creditOut  (creditOut)
    );

    dualClockFifoWithDataValid #(
        .WIDTH      (DATA_WIDTH),
        .DEPTH_LOG2 (DEPTH_LOG2),
        .SYNC_STAGES(SYNC_STAGES)
    ) fifo (
        .wrClk       (clk),
        .wrResetn    (producerResetn),
        .writeEnable (inValid),        // every valid word holds a credit
        .dataIn      (inData),
        .wrUsedCount (wrUsedCount),
        .rdClk       (coreClk),
        .rdResetn    (consumerResetn),
        .readEnable  (readEnable),
        .rdEmpty     (rdEmpty),
        .dataOutValid(outValid),
        .dataOut     (outData)
    );

    outputScheduler #(
        .OUT_CREDITS (OUT_CREDITS),
        .CREDIT_WIDTH(CREDIT_WIDTH)
    ) scheduler (
        .coreClk    (coreClk),
        .resetn     (consumerResetn),
        .outCreditIn(outCreditIn),
        .rdEmpty    (rdEmpty),
        .readEnable (readEnable)
    );

endmodule

// ==== source/creditIssuer.sv ====
`timescale 1ns/1ps

module creditIssuer import cdcPkg::*; #(
    parameter int DEPTH_LOG2   = DEPTH_LOG2_DEFAULT,
    parameter int CREDIT_WIDTH = cdcPkg::CREDIT_WIDTH
) (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic                  inValid,      // spends one credit
    input  logic [DEPTH_LOG2-1:0] wrUsedCount,
    output logic                  creditOut     // one pulse, one credit
);

    // one slot stays free to tell full from empty
    localparam logic [CREDIT_WIDTH:0] USABLE_SLOTS = (CREDIT_WIDTH + 1)'(2**DEPTH_LOG2 - 1);

    logic [CREDIT_WIDTH-1:0] outstanding;  // granted, word not yet seen
    logic [CREDIT_WIDTH:0]   pendingSum;
    logic                    grantNext;

    // words in the FIFO plus words that may still arrive
    assign pendingSum = {1'b0, outstanding}
                      + {{(CREDIT_WIDTH + 1 - DEPTH_LOG2){1'b0}}, wrUsedCount};
    assign grantNext  = (pendingSum < USABLE_SLOTS);

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            creditOut   <= 1'b0;
            outstanding <= '0;
        end else begin
            creditOut <= grantNext;
            case ({grantNext, inValid})
                2'b10:   outstanding <= outstanding + 1'b1;
                2'b01:   outstanding <= outstanding - 1'b1;
                default: outstanding <= outstanding; // both or neither cancel out
            endcase
        end
    end

endmodule

// ==== source/dualClockFifo.sv ====
`timescale 1ns/1ps

module dualClockFifo import cdcPkg::*; #(
    parameter int WIDTH       = DATA_WIDTH_DEFAULT,
    parameter int DEPTH_LOG2  = DEPTH_LOG2_DEFAULT,
    parameter int SYNC_STAGES = SYNC_STAGES_DEFAULT
) (
    input  logic                  wrClk,
    input  logic                  wrResetn,
    input  logic                  writeEnable,
    input  logic [WIDTH-1:0]      dataIn,
    output logic [DEPTH_LOG2-1:0] wrUsedCount,  // pessimistic, lags reads

    input  logic                  rdClk,
    input  logic                  rdResetn,
    input  logic                  readEnable,
    output logic                  rdEmpty,
    output logic [WIDTH-1:0]      dataOut       // valid the cycle after a read
);

    logic [WIDTH-1:0] memory [2**DEPTH_LOG2];

    logic [DEPTH_LOG2-1:0] wrPtr;
    logic [DEPTH_LOG2-1:0] wrPtrNext;
    logic [DEPTH_LOG2-1:0] wrGray;
    logic [DEPTH_LOG2-1:0] rdGraySync;  // read pointer as seen by the writer
    logic [DEPTH_LOG2-1:0] rdPtrSync;

    logic [DEPTH_LOG2-1:0] rdPtr;
    logic [DEPTH_LOG2-1:0] rdPtrNext;
    logic [DEPTH_LOG2-1:0] rdGray;
    logic [DEPTH_LOG2-1:0] wrGraySync;  // write pointer as seen by the reader
    logic [DEPTH_LOG2-1:0] wrPtrSync;
    logic                  isReading;

    function automatic logic [DEPTH_LOG2-1:0] binToGray(
        input logic [DEPTH_LOG2-1:0] bin
    );
        return bin ^ (bin >> 1);
    endfunction

    function automatic logic [DEPTH_LOG2-1:0] grayToBin(
        input logic [DEPTH_LOG2-1:0] gray
    );
        logic [DEPTH_LOG2-1:0] bin;
        bin[DEPTH_LOG2-1] = gray[DEPTH_LOG2-1];
        for (int i = DEPTH_LOG2 - 2; i >= 0; i--) begin
            bin[i] = bin[i+1] ^ gray[i];
        end
        return bin;
    endfunction

    assign wrPtrNext = wrPtr + 1'b1; // wraps at the depth
    assign rdPtrNext = rdPtr + 1'b1;

    // Gray copies are registered so the crossing sees glitch-free values
    always_ff @(posedge wrClk or negedge wrResetn) begin
        if (!wrResetn) begin
            wrPtr  <= '0;
            wrGray <= '0;
        end else if (writeEnable) begin
            wrPtr  <= wrPtrNext;
            wrGray <= binToGray(wrPtrNext);
        end
    end

    always_ff @(posedge wrClk) begin
        if (writeEnable) begin
            memory[wrPtr] <= dataIn;
        end
    end

    bitSynchronizer #(
        .WIDTH      (DEPTH_LOG2),
        .SYNC_STAGES(SYNC_STAGES)
    ) rdPtrSyncPipe (
        .clk      (wrClk),
        .aresetnIn(wrResetn),
        .dataIn   (rdGray),
        .dataOut  (rdGraySync)
    );

    assign rdPtrSync   = grayToBin(rdGraySync);
    assign wrUsedCount = wrPtr - rdPtrSync;

    bitSynchronizer #(
        .WIDTH      (DEPTH_LOG2),
        .SYNC_STAGES(SYNC_STAGES)
    ) wrPtrSyncPipe (
        .clk      (rdClk),
        .aresetnIn(rdResetn),
        .dataIn   (wrGray),
        .dataOut  (wrGraySync)
    );

    assign wrPtrSync = grayToBin(wrGraySync);
    assign rdEmpty   = (wrPtrSync == rdPtr);
    assign isReading = readEnable && !rdEmpty; // reads on empty are dropped

    always_ff @(posedge rdClk or negedge rdResetn) begin
        if (!rdResetn) begin
            rdPtr  <= '0;
            rdGray <= '0;
        end else if (isReading) begin
            rdPtr  <= rdPtrNext;
            rdGray <= binToGray(rdPtrNext);
        end
    end

    always_ff @(posedge rdClk) begin
        if (isReading) begin
            dataOut <= memory[rdPtr];
        end
    end

endmodule

// ==== source/dualClockFifoWithDataValid.sv ====
`timescale 1ns/1ps

module dualClockFifoWithDataValid import cdcPkg::*; #(
    parameter int WIDTH       = DATA_WIDTH_DEFAULT,
    parameter int DEPTH_LOG2  = DEPTH_LOG2_DEFAULT,
    parameter int SYNC_STAGES = SYNC_STAGES_DEFAULT
) (
    input  logic                  wrClk,
    input  logic                  wrResetn,
    input  logic                  writeEnable,
    input  logic [WIDTH-1:0]      dataIn,
    output logic [DEPTH_LOG2-1:0] wrUsedCount,

    input  logic                  rdClk,
    input  logic                  rdResetn,
    input  logic                  readEnable,
    output logic                  rdEmpty,
    output logic                  dataOutValid, // dataOut is fresh this cycle
    output logic [WIDTH-1:0]      dataOut
);

    logic [1:0] rdResetPipe;   // local reset tree for the read side
    logic       rdResetnLocal;

    always_ff @(posedge rdClk) begin
        rdResetPipe <= {rdResetPipe[0], rdResetn};
    end

    assign rdResetnLocal = rdResetPipe[1];

    always_ff @(posedge rdClk or negedge rdResetnLocal) begin
        if (!rdResetnLocal) begin
            dataOutValid <= 1'b0;
        end else begin
            dataOutValid <= readEnable && !rdEmpty;
        end
    end

    dualClockFifo #(
        .WIDTH      (WIDTH),
        .DEPTH_LOG2 (DEPTH_LOG2),
        .SYNC_STAGES(SYNC_STAGES)
    ) fifo (
        .wrClk      (wrClk),
        .wrResetn   (wrResetn),
        .writeEnable(writeEnable),
        .dataIn     (dataIn),
        .wrUsedCount(wrUsedCount),
        .rdClk      (rdClk),
        .rdResetn   (rdResetnLocal),
        .readEnable (readEnable),
        .rdEmpty    (rdEmpty),
        .dataOut    (dataOut)
    );

endmodule

// ==== source/outputScheduler.sv ====
`timescale 1ns/1ps

module outputScheduler import cdcPkg::*; #(
    parameter int OUT_CREDITS  = OUT_CREDITS_DEFAULT,
    parameter int CREDIT_WIDTH = cdcPkg::CREDIT_WIDTH
) (
    input  logic coreClk,
    input  logic resetn,
    input  logic outCreditIn, // consumer hands back one credit
    input  logic rdEmpty,
    output logic readEnable   // pop, outValid follows next cycle
);

    logic [CREDIT_WIDTH-1:0] creditCount;  // credits held from the consumer
    logic                    haveCredit;

    assign haveCredit = (creditCount != '0);
    assign readEnable = haveCredit && !rdEmpty;

    // a pop and a returned credit in one cycle leave the count unchanged
    always_ff @(posedge coreClk or negedge resetn) begin
        if (!resetn) begin
            creditCount <= CREDIT_WIDTH'(OUT_CREDITS);
        end else begin
            case ({readEnable, outCreditIn})
                2'b10:   creditCount <= creditCount - 1'b1;
                2'b01:   creditCount <= creditCount + 1'b1;
                default: creditCount <= creditCount;
            endcase
        end
    end

endmodule

// ==== source/resetSynchronizer.sv ====
`timescale 1ns/1ps

module resetSynchronizer import cdcPkg::*; #(
    parameter int SYNC_STAGES = SYNC_STAGES_DEFAULT
) (
    input  logic clk,
    input  logic aresetnIn,  // asynchronous, from the board
    output logic resetnOut   // asserts at once, releases on a clk edge
);

    logic [SYNC_STAGES-1:0] rstChain;

    // ones shift in after release, zeros everywhere as soon as reset falls
    always_ff @(posedge clk or negedge aresetnIn) begin
        if (!aresetnIn) begin
            rstChain <= '0;
        end else begin
            rstChain <= {rstChain[SYNC_STAGES-2:0], 1'b1};
        end
    end

    assign resetnOut = rstChain[SYNC_STAGES-1];

endmodule
